/* src.f */
src/memBusPkg.sv
src/accessPkg.sv
src/fetchPort.sv
src/dataPort.sv
src/busArbiter.sv
src/byteSequencer.sv
src/byteRam.sv
src/memSubsystem.sv
bench/clockGen.sv
bench/memSubsystemTb.sv

/* Makefile */
TOP := memSubsystemTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --top-module memSubsystem \
		src/memBusPkg.sv src/accessPkg.sv src/fetchPort.sv src/dataPort.sv \
		src/busArbiter.sv src/byteSequencer.sv src/byteRam.sv src/memSubsystem.sv

clean:
	rm -rf obj_dir

/* bench/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb;

    typedef logic [memBusPkg::addrWidth-1:0] addrType;
    typedef logic [memBusPkg::dataWidth-1:0] wordType;
    typedef logic [memBusPkg::byteWidth-1:0] byteType;

    localparam int doneTimeout = 100;
    localparam int windowSize = 32;
    localparam addrType windowBase = 'h800;

    logic                clk;
    logic                rst;
    logic                ioFull;
    logic                fetchReq;
    addrType             fetchAddr;
    logic                fetchDone;
    wordType             fetchInst;
    logic                dataReq;
    logic                dataWrite;
    accessPkg::accessLen dataLen;
    addrType             dataAddr;
    wordType             dataWdata;
    logic                dataDone;
    wordType             dataRdata;

    // reference copy of every byte stored so far
    byteType refMem [memBusPkg::ramDepth];

    clockGen clockGenInst (
        .clk (clk),
        .rst (rst)
    );

    memSubsystem uut (
        .clk       (clk),
        .rst       (rst),
        .ioFull    (ioFull),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataReq   (dataReq),
        .dataWrite (dataWrite),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic int lenBytes(accessPkg::accessLen len);
        case (len)
            accessPkg::lenByte: return 1;
            accessPkg::lenHalf: return 2;
            default:            return 4;
        endcase
    endfunction

    function automatic accessPkg::accessLen pickLen(int unsigned r);
        case (r % 3)
            0:       return accessPkg::lenByte;
            1:       return accessPkg::lenHalf;
            default: return accessPkg::lenWord;
        endcase
    endfunction

    // zero extended, byte k from address plus k
    function automatic wordType expectLoad(accessPkg::accessLen len, addrType addr);
        wordType word;
        word = '0;
        for (int k = 0; k < lenBytes(len); k++) begin
            word[k*memBusPkg::byteWidth +: memBusPkg::byteWidth] = refMem[addr + addrType'(k)];
        end
        return word;
    endfunction

    function automatic wordType expectFetch(addrType addr);
        return expectLoad(accessPkg::lenWord, addr - addrType'(addr % 4));
    endfunction

    task automatic checkWord(string name, wordType got, wordType exp);
        if (got !== exp) begin
            abortRun($sformatf("error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkLen(string name, accessPkg::accessLen len, wordType got, wordType exp);
        if (got !== exp) begin
            abortRun($sformatf("error at %0d ns: %s (%s) is %h, expected %h",
                               $time, name, len.name(), got, exp));
        end
    endtask

    task automatic waitDataDone();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #2;
            cycles++;
        end while (!dataDone && cycles < doneTimeout);
        if (!dataDone) begin
            abortRun($sformatf("dataDone never came within %0d cycles", doneTimeout));
        end
        dataReq = 1'b0;
    endtask

    task automatic waitFetchDone();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #2;
            cycles++;
        end while (!fetchDone && cycles < doneTimeout);
        if (!fetchDone) begin
            abortRun($sformatf("fetchDone never came within %0d cycles", doneTimeout));
        end
        fetchReq = 1'b0;
    endtask

    task automatic startData(logic write, accessPkg::accessLen len, addrType addr, wordType wdata);
        @(posedge clk);
        #2;
        dataWrite = write;
        dataLen   = len;
        dataAddr  = addr;
        dataWdata = wdata;
        dataReq   = 1'b1;
    endtask

    task automatic storeData(accessPkg::accessLen len, addrType addr, wordType wdata);
        startData(1'b1, len, addr, wdata);
        waitDataDone();
        for (int k = 0; k < lenBytes(len); k++) begin
            refMem[addr + addrType'(k)] = wdata[k*memBusPkg::byteWidth +: memBusPkg::byteWidth];
        end
    endtask

    task automatic loadCheck(accessPkg::accessLen len, addrType addr);
        startData(1'b0, len, addr, '0);
        waitDataDone();
        checkLen("dataRdata", len, dataRdata, expectLoad(len, addr));
    endtask

    task automatic fetchCheck(addrType addr);
        @(posedge clk);
        #2;
        fetchAddr = addr;
        fetchReq  = 1'b1;
        waitFetchDone();
        checkWord("fetchInst", fetchInst, expectFetch(addr));
    endtask

    // fetch and load raised in the same cycle
    task automatic raceCheck(addrType fAddr, addrType dAddr);
        int cycles;
        int dataAt;
        int fetchAt;
        wordType instGot;
        wordType dataGot;
        @(posedge clk);
        #2;
        fetchAddr = fAddr;
        fetchReq  = 1'b1;
        dataWrite = 1'b0;
        dataLen   = accessPkg::lenWord;
        dataAddr  = dAddr;
        dataReq   = 1'b1;
        cycles  = 0;
        dataAt  = -1;
        fetchAt = -1;
        instGot = '0;
        dataGot = '0;
        while ((dataAt < 0 || fetchAt < 0) && cycles < doneTimeout) begin
            @(posedge clk);
            #2;
            cycles++;
            if (dataDone) begin
                dataAt  = cycles;
                dataGot = dataRdata;
                dataReq = 1'b0;
            end
            if (fetchDone) begin
                fetchAt  = cycles;
                instGot  = fetchInst;
                fetchReq = 1'b0;
            end
        end
        if (dataAt < 0) begin
            abortRun("dataDone never came while a fetch was pending");
        end
        if (fetchAt < 0) begin
            abortRun("fetchDone never came after the competing load");
        end
        if (fetchAt <= dataAt) begin
            abortRun("fetchDone came before dataDone although data has priority");
        end
        checkWord("dataRdata", dataGot, expectLoad(accessPkg::lenWord, dAddr));
        checkWord("fetchInst", instGot, expectFetch(fAddr));
    endtask

    task automatic frozenCheck(addrType addr);
        @(posedge clk);
        #2;
        ioFull = 1'b1;
        startData(1'b0, accessPkg::lenWord, addr, '0);
        for (int cycles = 0; cycles < 30; cycles++) begin
            @(posedge clk);
            #2;
            if (dataDone || fetchDone) begin
                abortRun("a done pulse appeared while ioFull was high");
            end
        end
        ioFull = 1'b0;
        waitDataDone();
        checkLen("dataRdata", accessPkg::lenWord, dataRdata, expectLoad(accessPkg::lenWord, addr));
    endtask

    task automatic randomMix(int count);
        int unsigned op;
        int off;
        accessPkg::accessLen len;
        // fill the window so every load sees defined bytes
        for (int w = 0; w < windowSize; w += 4) begin
            storeData(accessPkg::lenWord, windowBase + addrType'(w), $urandom());
        end
        for (int i = 0; i < count; i++) begin
            op  = $urandom_range(0, 2);
            len = pickLen($urandom());
            off = $urandom_range(0, windowSize - 1);
            off = off - (off % lenBytes(len));
            if (op == 0) begin
                storeData(len, windowBase + addrType'(off), $urandom());
            end else if (op == 1) begin
                loadCheck(len, windowBase + addrType'(off));
            end else begin
                fetchCheck(windowBase + addrType'(off));
            end
        end
    endtask

    initial begin
        int cycles;
        ioFull    = 1'b0;
        fetchReq  = 1'b0;
        fetchAddr = '0;
        dataReq   = 1'b0;
        dataWrite = 1'b0;
        dataLen   = accessPkg::lenByte;
        dataAddr  = '0;
        dataWdata = '0;
        void'($urandom(30160));

        cycles = 0;
        do begin
            @(posedge clk);
            #2;
            cycles++;
        end while (rst && cycles < 50);
        if (rst) begin
            abortRun("reset never released");
        end

        // word store, then fetch of the same word
        storeData(accessPkg::lenWord, 'h100, 'hdeadbeef);
        fetchCheck('h100);
        fetchCheck('h102);

        // partial stores merged into one word
        storeData(accessPkg::lenWord, 'h200, 'h11223344);
        storeData(accessPkg::lenByte, 'h201, 'h5a5a_a0ab);
        storeData(accessPkg::lenHalf, 'h202, 'h7777_cdef);
        loadCheck(accessPkg::lenWord, 'h200);

        loadCheck(accessPkg::lenByte, 'h201);
        loadCheck(accessPkg::lenByte, 'h203);
        loadCheck(accessPkg::lenHalf, 'h202);
        loadCheck(accessPkg::lenHalf, 'h200);

        raceCheck('h100, 'h200);
        frozenCheck('h100);

        randomMix(200);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* bench/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for ten rising edges
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* src/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ioFull,

    input  logic                              fetchReq,
    input  logic [memBusPkg::addrWidth-1:0]   fetchAddr,
    output logic                              fetchDone,
    output logic [memBusPkg::dataWidth-1:0]   fetchInst,

    input  logic                              dataReq,
    input  logic                              dataWrite,
    input  accessPkg::accessLen               dataLen,
    input  logic [memBusPkg::addrWidth-1:0]   dataAddr,
    input  logic [memBusPkg::dataWidth-1:0]   dataWdata,
    output logic                              dataDone,
    output logic [memBusPkg::dataWidth-1:0]   dataRdata
);

    logic                              fetchCyc;
    logic                              fetchStb;
    logic [memBusPkg::addrWidth-1:0]   fetchAdr;
    logic                              fetchAck;
    logic [memBusPkg::dataWidth-1:0]   fetchDatR;

    logic                              dataCyc;
    logic                              dataStb;
    logic                              dataWe;
    logic [memBusPkg::selWidth-1:0]    dataSel;
    logic [memBusPkg::addrWidth-1:0]   dataAdr;
    logic [memBusPkg::dataWidth-1:0]   dataDatW;
    logic                              dataAck;
    logic [memBusPkg::dataWidth-1:0]   dataDatR;

    logic                              memCyc;
    logic                              memStb;
    logic                              memWe;
    logic [memBusPkg::selWidth-1:0]    memSel;
    logic [memBusPkg::addrWidth-1:0]   memAdr;
    logic [memBusPkg::dataWidth-1:0]   memDatW;
    logic                              memAck;
    logic [memBusPkg::dataWidth-1:0]   memDatR;

    logic                              ramEn;
    logic                              ramWe;
    logic [memBusPkg::addrWidth-1:0]   ramAddr;
    logic [memBusPkg::byteWidth-1:0]   ramWdata;
    logic [memBusPkg::byteWidth-1:0]   ramRdata;

    fetchPort fetchPortInst (
        .clk       (clk),
        .rst       (rst),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .fetchCyc  (fetchCyc),
        .fetchStb  (fetchStb),
        .fetchAdr  (fetchAdr),
        .fetchAck  (fetchAck),
        .fetchDatR (fetchDatR)
    );

    dataPort dataPortInst (
        .clk       (clk),
        .rst       (rst),
        .dataReq   (dataReq),
        .dataWrite (dataWrite),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .dataCyc   (dataCyc),
        .dataStb   (dataStb),
        .dataWe    (dataWe),
        .dataSel   (dataSel),
        .dataAdr   (dataAdr),
        .dataDatW  (dataDatW),
        .dataAck   (dataAck),
        .dataDatR  (dataDatR)
    );

    busArbiter busArbiterInst (
        .clk       (clk),
        .rst       (rst),
        .ioFull    (ioFull),
        .fetchCyc  (fetchCyc),
        .fetchStb  (fetchStb),
        .fetchAdr  (fetchAdr),
        .fetchAck  (fetchAck),
        .fetchDatR (fetchDatR),
        .dataCyc   (dataCyc),
        .dataStb   (dataStb),
        .dataWe    (dataWe),
        .dataSel   (dataSel),
        .dataAdr   (dataAdr),
        .dataDatW  (dataDatW),
        .dataAck   (dataAck),
        .dataDatR  (dataDatR),
        .memCyc    (memCyc),
        .memStb    (memStb),
        .memWe     (memWe),
        .memSel    (memSel),
        .memAdr    (memAdr),
        .memDatW   (memDatW),
        .memAck    (memAck),
        .memDatR   (memDatR)
    );

    byteSequencer byteSequencerInst (
        .clk      (clk),
        .rst      (rst),
        .memCyc   (memCyc),
        .memStb   (memStb),
        .memWe    (memWe),
        .memSel   (memSel),
        .memAdr   (memAdr),
        .memDatW  (memDatW),
        .memAck   (memAck),
        .memDatR  (memDatR),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam byteRamInst (
        .clk      (clk),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

/* src/byteRam.sv */
`timescale 1ns/1ps

module byteRam (
    input  logic                              clk,
    input  logic                              ramEn,
    input  logic                              ramWe,
    input  logic [memBusPkg::addrWidth-1:0]   ramAddr,
    input  logic [memBusPkg::byteWidth-1:0]   ramWdata,
    output logic [memBusPkg::byteWidth-1:0]   ramRdata
);

    logic [memBusPkg::byteWidth-1:0] mem [memBusPkg::ramDepth];

    // single port, read data registered
    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[ramAddr] <= ramWdata;
            end else begin
                ramRdata <= mem[ramAddr];
            end
        end
    end

endmodule

/* src/byteSequencer.sv */
`timescale 1ns/1ps

module byteSequencer (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              memCyc,
    input  logic                              memStb,
    input  logic                              memWe,
    input  logic [memBusPkg::selWidth-1:0]    memSel,
    input  logic [memBusPkg::addrWidth-1:0]   memAdr,
    input  logic [memBusPkg::dataWidth-1:0]   memDatW,
    output logic                              memAck,
    output logic [memBusPkg::dataWidth-1:0]   memDatR,

    output logic                              ramEn,
    output logic                              ramWe,
    output logic [memBusPkg::addrWidth-1:0]   ramAddr,
    output logic [memBusPkg::byteWidth-1:0]   ramWdata,
    input  logic [memBusPkg::byteWidth-1:0]   ramRdata
);

    typedef enum logic [1:0] {
        stIdle,
        stAccess,
        stDrain,
        stAck
    } seqState;

    typedef logic [$clog2(memBusPkg::selWidth)-1:0] byteIdx;

    seqState                         state;
    logic [memBusPkg::selWidth-1:0]  pending;
    logic [memBusPkg::selWidth-1:0]  pendingNext;
    byteIdx                          curIdx;
    byteIdx                          rdIdx;
    logic                            rdCapture;

    function automatic byteIdx lowestSet(input logic [memBusPkg::selWidth-1:0] mask);
        byteIdx idx;
        idx = '0;
        for (int i = memBusPkg::selWidth - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = byteIdx'(i);
            end
        end
        return idx;
    endfunction

    // one byte lane per cycle, lowest select first
    assign curIdx      = lowestSet(pending);
    assign pendingNext = pending & ~(memBusPkg::selWidth'(1) << curIdx);

    assign memAck   = (state == stAck);
    assign ramEn    = (state == stAccess);
    assign ramWe    = (state == stAccess) && memWe;
    assign ramAddr  = memAdr + memBusPkg::addrWidth'(curIdx);
    assign ramWdata = memDatW[curIdx * memBusPkg::byteWidth +: memBusPkg::byteWidth];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stIdle;
            pending   <= '0;
            rdCapture <= 1'b0;
        end else begin
            rdCapture <= (state == stAccess) && !memWe;
            case (state)
                stIdle: begin
                    if (memCyc && memStb) begin
                        pending <= memSel;
                        // an empty select mask just acks
                        state   <= (memSel == '0) ? stAck : stAccess;
                    end
                end
                stAccess: begin
                    pending <= pendingNext;
                    if (pendingNext == '0) begin
                        state <= memWe ? stAck : stDrain;
                    end
                end
                stDrain: begin
                    state <= stAck;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // read byte returns one cycle after its access
    always_ff @(posedge clk) begin
        if (state == stAccess) begin
            rdIdx <= curIdx;
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && memCyc && memStb) begin
            // unselected lanes read as zero
            memDatR <= '0;
        end else if (rdCapture) begin
            memDatR[rdIdx * memBusPkg::byteWidth +: memBusPkg::byteWidth] <= ramRdata;
        end
    end

endmodule

/* src/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ioFull,

    input  logic                              fetchCyc,
    input  logic                              fetchStb,
    input  logic [memBusPkg::addrWidth-1:0]   fetchAdr,
    output logic                              fetchAck,
    output logic [memBusPkg::dataWidth-1:0]   fetchDatR,

    input  logic                              dataCyc,
    input  logic                              dataStb,
    input  logic                              dataWe,
    input  logic [memBusPkg::selWidth-1:0]    dataSel,
    input  logic [memBusPkg::addrWidth-1:0]   dataAdr,
    input  logic [memBusPkg::dataWidth-1:0]   dataDatW,
    output logic                              dataAck,
    output logic [memBusPkg::dataWidth-1:0]   dataDatR,

    output logic                              memCyc,
    output logic                              memStb,
    output logic                              memWe,
    output logic [memBusPkg::selWidth-1:0]    memSel,
    output logic [memBusPkg::addrWidth-1:0]   memAdr,
    output logic [memBusPkg::dataWidth-1:0]   memDatW,
    input  logic                              memAck,
    input  logic [memBusPkg::dataWidth-1:0]   memDatR
);

    accessPkg::requester owner;
    logic                busy;
    logic                dataOwns;

    assign dataOwns = (owner == accessPkg::reqData);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            owner <= accessPkg::reqFetch;
        end else if (busy) begin
            if (memAck) begin
                busy <= 1'b0;
            end
        end else if (!ioFull && (dataCyc || fetchCyc)) begin
            // data side has priority
            busy  <= 1'b1;
            owner <= dataCyc ? accessPkg::reqData : accessPkg::reqFetch;
        end
    end

    assign memCyc  = busy && (dataOwns ? dataCyc : fetchCyc);
    assign memStb  = busy && (dataOwns ? dataStb : fetchStb);
    assign memAdr  = dataOwns ? dataAdr : fetchAdr;

    // fetches are always full word reads
    assign memWe   = dataOwns && dataWe;
    assign memSel  = dataOwns ? dataSel : {memBusPkg::selWidth{1'b1}};
    assign memDatW = dataOwns ? dataDatW : '0;

    assign fetchAck  = busy && !dataOwns && memAck;
    assign dataAck   = busy && dataOwns && memAck;
    assign fetchDatR = dataOwns ? '0 : memDatR;
    assign dataDatR  = dataOwns ? memDatR : '0;

endmodule

/* src/dataPort.sv */
`timescale 1ns/1ps

module dataPort (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              dataReq,
    input  logic                              dataWrite,
    input  accessPkg::accessLen               dataLen,
    input  logic [memBusPkg::addrWidth-1:0]   dataAddr,
    input  logic [memBusPkg::dataWidth-1:0]   dataWdata,
    output logic                              dataDone,
    output logic [memBusPkg::dataWidth-1:0]   dataRdata,

    output logic                              dataCyc,
    output logic                              dataStb,
    output logic                              dataWe,
    output logic [memBusPkg::selWidth-1:0]    dataSel,
    output logic [memBusPkg::addrWidth-1:0]   dataAdr,
    output logic [memBusPkg::dataWidth-1:0]   dataDatW,
    input  logic                              dataAck,
    input  logic [memBusPkg::dataWidth-1:0]   dataDatR
);

    localparam int padHalf = memBusPkg::dataWidth - 2 * memBusPkg::byteWidth;
    localparam int padByte = memBusPkg::dataWidth - memBusPkg::byteWidth;

    accessPkg::accessLen lenQ;
    logic                startReq;

    assign startReq = dataReq && !dataCyc && !dataDone;
    assign dataStb  = dataCyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            dataCyc  <= 1'b0;
            dataDone <= 1'b0;
        end else begin
            dataDone <= 1'b0;
            if (dataCyc) begin
                if (dataAck) begin
                    dataCyc  <= 1'b0;
                    dataDone <= 1'b1;
                end
            end else if (startReq) begin
                dataCyc <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startReq) begin
            dataAdr  <= dataAddr;
            dataWe   <= dataWrite;
            dataDatW <= dataWdata;
            lenQ     <= dataLen;
            case (dataLen)
                accessPkg::lenByte: dataSel <= 4'b0001;
                accessPkg::lenHalf: dataSel <= 4'b0011;
                default:            dataSel <= 4'b1111;
            endcase
        end
        // stores leave the last load result alone
        if (dataCyc && dataAck && !dataWe) begin
            case (lenQ)
                accessPkg::lenByte:
                    dataRdata <= {{padByte{1'b0}}, dataDatR[memBusPkg::byteWidth-1:0]};
                accessPkg::lenHalf:
                    dataRdata <= {{padHalf{1'b0}}, dataDatR[2*memBusPkg::byteWidth-1:0]};
                default:
                    dataRdata <= dataDatR;
            endcase
        end
    end

endmodule

/* src/fetchPort.sv */
`timescale 1ns/1ps

module fetchPort (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              fetchReq,
    input  logic [memBusPkg::addrWidth-1:0]   fetchAddr,
    output logic                              fetchDone,
    output logic [memBusPkg::dataWidth-1:0]   fetchInst,

    output logic                              fetchCyc,
    output logic                              fetchStb,
    output logic [memBusPkg::addrWidth-1:0]   fetchAdr,
    input  logic                              fetchAck,
    input  logic [memBusPkg::dataWidth-1:0]   fetchDatR
);

    // stb always travels with cyc for a classic single read
    assign fetchStb = fetchCyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchCyc  <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= 1'b0;
            if (fetchCyc) begin
                if (fetchAck) begin
                    fetchCyc  <= 1'b0;
                    fetchDone <= 1'b1;
                end
            end else if (fetchReq && !fetchDone) begin
                fetchCyc <= 1'b1;
            end
        end
    end

    // address and instruction word are payload only
    always_ff @(posedge clk) begin
        if (!fetchCyc && !fetchDone && fetchReq) begin
            // instructions are always word aligned
            fetchAdr <= {fetchAddr[memBusPkg::addrWidth-1:2], 2'b00};
        end
        if (fetchCyc && fetchAck) begin
            fetchInst <= fetchDatR;
        end
    end

endmodule

/* src/accessPkg.sv */
package accessPkg;

    // length of a load or store
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } accessLen;

    // current owner of the shared bus
    typedef enum logic {
        reqFetch = 1'b0,
        reqData  = 1'b1
    } requester;

endpackage

/* src/memBusPkg.sv */
package memBusPkg;

    // byte address into the RAM
    localparam int addrWidth = 17;

    // word carried on the Wishbone side
    localparam int dataWidth = 32;

    // the RAM itself is one byte wide
    localparam int byteWidth = 8;

    // one select bit per byte lane
    localparam int selWidth = dataWidth / byteWidth;

    localparam int ramDepth = 1 << addrWidth;

endpackage
